/* Bender.yml */
package:
  name: write_guard

sources:
  - write_guard_pkg.sv
  - wg_fault_log.sv
  - wg_timer_bank.sv
  - wg_w_order_fifo.sv
  - wg_slot_table.sv
  - wg_ctrl.sv
  - write_guard.sv
  - target: test
    files:
      - write_guard_assert.sv
      - tb_write_guard.sv

/* tb_write_guard.sv */
`timescale 1ns/1ps

module tb_write_guard;
  import write_guard_pkg::*;

  localparam int unsigned NumSlots = 4;
  // The six tests take about 200 cycles, the limit leaves a wide margin
  localparam int unsigned MaxCycles = 3000;

  logic                 clk;
  logic                 rst_n;
  logic                 aw_valid;
  logic                 aw_ready;
  logic [IdWidth-1:0]   aw_id;
  logic [AddrWidth-1:0] aw_addr;
  logic [LenWidth-1:0]  aw_len;
  logic                 w_valid;
  logic                 w_ready;
  logic                 w_last;
  logic                 b_valid;
  logic                 b_ready;
  logic [IdWidth-1:0]   b_id;
  logic [CntWidth-1:0]  budget_aw;
  logic [CntWidth-1:0]  budget_w;
  logic [CntWidth-1:0]  budget_b;
  logic                 clear;
  logic                 irq;
  logic                 reset_req;
  fault_e               fault_cause;
  logic [AddrWidth-1:0] fault_addr;
  int                   seed;
  int unsigned          cycles;

  write_guard #(
    .NumSlots (NumSlots)
  ) uut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .aw_valid_i    (aw_valid),
    .aw_ready_i    (aw_ready),
    .aw_id_i       (aw_id),
    .aw_addr_i     (aw_addr),
    .aw_len_i      (aw_len),
    .w_valid_i     (w_valid),
    .w_ready_i     (w_ready),
    .w_last_i      (w_last),
    .b_valid_i     (b_valid),
    .b_ready_i     (b_ready),
    .b_id_i        (b_id),
    .budget_aw_i   (budget_aw),
    .budget_w_i    (budget_w),
    .budget_b_i    (budget_b),
    .clear_i       (clear),
    .irq_o         (irq),
    .reset_req_o   (reset_req),
    .fault_cause_o (fault_cause),
    .fault_addr_o  (fault_addr)
  );

  bind write_guard write_guard_assert i_assert (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .irq_o         (irq_o),
    .reset_req_o   (reset_req_o),
    .fault_cause_o (fault_cause_o)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Run did not finish within %0d cycles", MaxCycles);
      $display("Test FAILED");
      $fatal(1, "Cycle limit reached");
    end
  end

  // Stop at the first failed bound assertion
  always @(negedge clk) begin
    if (uut.i_assert.fail_cnt != 0) begin
      $display("A bound assertion on the watchdog outputs failed");
      $display("Test FAILED");
      $fatal(1, "Assertion failure");
    end
  end

  task automatic check_equal(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Test FAILED");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic wait_irq(input int max_cycles);
    int n;
    n = 0;
    @(negedge clk);
    while ((irq !== 1'b1) && (n < max_cycles)) begin
      @(negedge clk);
      n++;
    end
    if (irq !== 1'b1) begin
      $display("Watchdog raised no interrupt within %0d cycles", max_cycles);
      $display("Test FAILED");
      $fatal(1, "Missing interrupt");
    end
  endtask

  task automatic aw_send(input logic [IdWidth-1:0] id, input logic [AddrWidth-1:0] addr,
                         input logic [LenWidth-1:0] len);
    @(posedge clk);
    aw_valid <= 1'b1;
    aw_ready <= 1'b1;
    aw_id    <= id;
    aw_addr  <= addr;
    aw_len   <= len;
    @(posedge clk);
    aw_valid <= 1'b0;
    aw_ready <= 1'b0;
  endtask

  // Beats back to back, last flag only on the final beat when asked for
  task automatic w_burst(input int beats, input logic with_last);
    for (int i = 0; i < beats; i++) begin
      @(posedge clk);
      w_valid <= 1'b1;
      w_ready <= 1'b1;
      w_last  <= with_last && (i == beats - 1);
    end
    @(posedge clk);
    w_valid <= 1'b0;
    w_ready <= 1'b0;
    w_last  <= 1'b0;
  endtask

  task automatic b_send(input logic [IdWidth-1:0] id);
    @(posedge clk);
    b_valid <= 1'b1;
    b_ready <= 1'b1;
    b_id    <= id;
    @(posedge clk);
    b_valid <= 1'b0;
    b_ready <= 1'b0;
  endtask

  task automatic pulse_clear();
    @(posedge clk);
    clear <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
    @(negedge clk);
    check_equal("irq after clear", irq, 1'b0);
    check_equal("reset request after clear", reset_req, 1'b0);
    check_equal("cause after clear", fault_cause, FAULT_NONE);
  endtask

  task automatic test_clean_traffic();
    logic [IdWidth-1:0] id;
    id = IdWidth'($random(seed));
    for (int i = 0; i < 3; i++) begin
      aw_send(id + IdWidth'(i), $random(seed), LenWidth'(i));
    end
    for (int i = 0; i < 3; i++) begin
      w_burst(i + 1, 1'b1);
    end
    // Different IDs may respond in any order
    for (int i = 2; i >= 0; i--) begin
      b_send(id + IdWidth'(i));
    end
    @(negedge clk);
    check_equal("irq after clean traffic", irq, 1'b0);
    check_equal("cause after clean traffic", fault_cause, FAULT_NONE);
    pulse_clear();
  endtask

  task automatic test_same_id_order();
    logic [IdWidth-1:0] id;
    id = IdWidth'($random(seed));
    aw_send(id, $random(seed), 8'd0);
    aw_send(id, $random(seed), 8'd0);
    w_burst(1, 1'b1);
    w_burst(1, 1'b1);
    b_send(id);
    b_send(id);
    @(negedge clk);
    check_equal("irq after two same-ID responses", irq, 1'b0);
    // Nothing left waiting for this ID
    b_send(id);
    wait_irq(10);
    check_equal("cause for extra response", fault_cause, FAULT_UNWANTED_B);
    pulse_clear();
  endtask

  task automatic test_late_last_beat();
    logic [AddrWidth-1:0] addr;
    addr = $random(seed);
    @(posedge clk);
    budget_w <= 16'd2;
    aw_send(IdWidth'($random(seed)), addr, 8'd3);
    w_burst(3, 1'b0);
    wait_irq(30);
    check_equal("cause for late last beat", fault_cause, FAULT_W_TIMEOUT);
    check_equal("address for late last beat", fault_addr, addr);
    // The late last beat still retires its FIFO entry
    w_burst(1, 1'b1);
    budget_w <= 16'd10;
    pulse_clear();
  endtask

  task automatic test_late_response();
    logic [AddrWidth-1:0] addr;
    addr = $random(seed);
    @(posedge clk);
    budget_b <= 16'd5;
    aw_send(IdWidth'($random(seed)), addr, 8'd1);
    w_burst(2, 1'b1);
    wait_irq(30);
    check_equal("cause for late response", fault_cause, FAULT_B_TIMEOUT);
    check_equal("address for late response", fault_addr, addr);
    @(posedge clk);
    budget_b <= 16'd40;
    pulse_clear();
  endtask

  task automatic test_aw_stall();
    logic [AddrWidth-1:0] addr;
    addr = $random(seed);
    @(posedge clk);
    budget_aw <= 16'd6;
    aw_valid  <= 1'b1;
    aw_ready  <= 1'b0;
    aw_addr   <= addr;
    wait_irq(30);
    check_equal("cause for address stall", fault_cause, FAULT_AW_STALL);
    check_equal("address for address stall", fault_addr, addr);
    @(posedge clk);
    aw_valid <= 1'b0;
    // Table is empty, so this response is unwanted but must not replace the cause
    b_send(IdWidth'($random(seed)));
    @(negedge clk);
    check_equal("irq kept after second fault", irq, 1'b1);
    check_equal("first cause kept", fault_cause, FAULT_AW_STALL);
    @(posedge clk);
    budget_aw <= 16'd40;
    pulse_clear();
  endtask

  task automatic test_table_full();
    logic [AddrWidth-1:0] addr;
    for (int i = 0; i < NumSlots; i++) begin
      aw_send(IdWidth'($random(seed)), $random(seed), 8'd3);
    end
    @(negedge clk);
    check_equal("irq with full table", irq, 1'b0);
    addr = $random(seed);
    aw_send(IdWidth'($random(seed)), addr, 8'd3);
    wait_irq(10);
    check_equal("cause for full table", fault_cause, FAULT_TABLE_FULL);
    check_equal("address for full table", fault_addr, addr);
    // Let the open slots time out, then retire their FIFO entries
    repeat (60) @(negedge clk);
    check_equal("cause after later timeouts", fault_cause, FAULT_TABLE_FULL);
    for (int i = 0; i < NumSlots; i++) begin
      w_burst(1, 1'b1);
    end
    pulse_clear();
  endtask

  initial begin
    seed      = 32'hba3a;
    cycles    = 0;
    clk       = 1'b0;
    rst_n     = 1'b0;
    aw_valid  = 1'b0;
    aw_ready  = 1'b0;
    aw_id     = '0;
    aw_addr   = '0;
    aw_len    = '0;
    w_valid   = 1'b0;
    w_ready   = 1'b0;
    w_last    = 1'b0;
    b_valid   = 1'b0;
    b_ready   = 1'b0;
    b_id      = '0;
    budget_aw = 16'd40;
    budget_w  = 16'd10;
    budget_b  = 16'd40;
    clear     = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_equal("irq after reset", irq, 1'b0);
    check_equal("cause after reset", fault_cause, FAULT_NONE);
    test_clean_traffic();
    test_same_id_order();
    test_late_last_beat();
    test_late_response();
    test_aw_stall();
    test_table_full();
    if (uut.i_assert.fail_cnt != 0) begin
      $display("A bound assertion on the watchdog outputs failed");
      $display("Test FAILED");
      $fatal(1, "Assertion failure");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

/* vlog.f */
write_guard_pkg.sv
wg_fault_log.sv
wg_timer_bank.sv
wg_w_order_fifo.sv
wg_slot_table.sv
wg_ctrl.sv
write_guard.sv
write_guard_assert.sv
tb_write_guard.sv

/* wg_ctrl.sv */
`timescale 1ns/1ps

module wg_ctrl #(
  parameter  int unsigned NumSlots = 4,
  localparam int unsigned IdxWidth = (NumSlots > 1) ? $clog2(NumSlots) : 1
) (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic                                                aw_valid_i,
  input  logic                                                aw_ready_i,
  input  logic                                                w_valid_i,
  input  logic                                                w_ready_i,
  input  logic                                                w_last_i,
  input  logic                                                b_valid_i,
  input  logic                                                b_ready_i,
  input  logic                                                free_found_i,
  input  logic [IdxWidth-1:0]                                 free_idx_i,
  input  logic                                                rsp_match_i,
  input  logic [IdxWidth-1:0]                                 rsp_idx_i,
  input  logic [IdxWidth-1:0]                                 w_head_i,
  input  logic                                                w_empty_i,
  input  logic [NumSlots-1:0]                                 expire_i,
  input  logic                                                aw_stall_expire_i,
  input  write_guard_pkg::phase_e [NumSlots-1:0]              phase_i,
  input  logic [NumSlots-1:0][write_guard_pkg::AddrWidth-1:0] slot_addr_i,
  input  logic [write_guard_pkg::AddrWidth-1:0]               aw_addr_i,
  output logic                                                alloc_o,
  output logic [IdxWidth-1:0]                                 alloc_idx_o,
  output logic                                                to_resp_o,
  output logic [IdxWidth-1:0]                                 resp_idx_o,
  output logic [NumSlots-1:0]                                 release_o,
  output logic                                                fault_req_o,
  output write_guard_pkg::fault_e                             fault_cause_o,
  output logic [write_guard_pkg::AddrWidth-1:0]               fault_addr_o
);
  import write_guard_pkg::*;

  logic aw_hs;
  logic w_last_hs;
  logic b_hs;
  logic aw_stall;
  logic stall_seen_q;

  assign aw_hs     = aw_valid_i && aw_ready_i;
  assign w_last_hs = w_valid_i && w_ready_i && w_last_i;
  assign b_hs      = b_valid_i && b_ready_i;
  assign aw_stall  = aw_valid_i && !aw_ready_i;

  assign alloc_o     = aw_hs && free_found_i;
  assign alloc_idx_o = free_idx_i;

  // Head slot moves on, unless it already timed out or expires right now
  assign to_resp_o  = w_last_hs && !w_empty_i && (phase_i[w_head_i] == PH_DATA) &&
                      !expire_i[w_head_i];
  assign resp_idx_o = w_head_i;

  // One report per stall, even if the stall counter wraps around
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stall_seen_q <= 1'b0;
    end else if (!aw_stall) begin
      stall_seen_q <= 1'b0;
    end else if (aw_stall_expire_i) begin
      stall_seen_q <= 1'b1;
    end
  end

  // Later assignments win, so slot expiry has the highest priority
  always_comb begin
    release_o     = '0;
    fault_req_o   = 1'b0;
    fault_cause_o = FAULT_NONE;
    fault_addr_o  = '0;
    if (aw_stall_expire_i && !stall_seen_q) begin
      fault_req_o   = 1'b1;
      fault_cause_o = FAULT_AW_STALL;
      fault_addr_o  = aw_addr_i;
    end
    if (aw_hs && !free_found_i) begin
      fault_req_o   = 1'b1;
      fault_cause_o = FAULT_TABLE_FULL;
      fault_addr_o  = aw_addr_i;
    end
    if (b_hs) begin
      if (rsp_match_i) begin
        release_o[rsp_idx_i] = 1'b1;
      end else begin
        fault_req_o   = 1'b1;
        fault_cause_o = FAULT_UNWANTED_B;
        fault_addr_o  = '0;
      end
    end
    // Descending scan leaves the lowest expired slot in the report
    for (int i = NumSlots - 1; i >= 0; i--) begin
      if (expire_i[i]) begin
        release_o[i]  = 1'b1;
        fault_req_o   = 1'b1;
        fault_cause_o = (phase_i[i] == PH_DATA) ? FAULT_W_TIMEOUT : FAULT_B_TIMEOUT;
        fault_addr_o  = slot_addr_i[i];
      end
    end
  end

endmodule

/* wg_fault_log.sv */
`timescale 1ns/1ps

module wg_fault_log (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  fault_req_i,
  input  write_guard_pkg::fault_e               fault_cause_i,
  input  logic [write_guard_pkg::AddrWidth-1:0] fault_addr_i,
  input  logic                                  clear_i,
  output logic                                  irq_o,
  output logic                                  reset_req_o,
  output write_guard_pkg::fault_e               fault_cause_o,
  output logic [write_guard_pkg::AddrWidth-1:0] fault_addr_o
);
  import write_guard_pkg::*;

  logic                 active_q;
  fault_e               cause_q;
  logic [AddrWidth-1:0] addr_q;
  logic                 capture;

  // A clear in the same cycle frees the log for the new request
  assign capture = fault_req_i && (!active_q || clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      cause_q  <= FAULT_NONE;
    end else if (capture) begin
      active_q <= 1'b1;
      cause_q  <= fault_cause_i;
    end else if (clear_i) begin
      active_q <= 1'b0;
      cause_q  <= FAULT_NONE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      addr_q <= fault_addr_i;
    end
  end

  // Interrupt and reset request share one level
  assign irq_o         = active_q;
  assign reset_req_o   = active_q;
  assign fault_cause_o = cause_q;
  assign fault_addr_o  = addr_q;

endmodule

/* wg_slot_table.sv */
`timescale 1ns/1ps

module wg_slot_table #(
  parameter  int unsigned NumSlots = 4,
  localparam int unsigned IdxWidth = (NumSlots > 1) ? $clog2(NumSlots) : 1
) (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic                                                alloc_i,
  input  logic [IdxWidth-1:0]                                 alloc_idx_i,
  input  logic [write_guard_pkg::IdWidth-1:0]                 aw_id_i,
  input  logic [write_guard_pkg::AddrWidth-1:0]               aw_addr_i,
  input  logic                                                to_resp_i,
  input  logic [IdxWidth-1:0]                                 resp_idx_i,
  input  logic [NumSlots-1:0]                                 release_i,
  input  logic [write_guard_pkg::IdWidth-1:0]                 b_id_i,
  output logic                                                free_found_o,
  output logic [IdxWidth-1:0]                                 free_idx_o,
  output logic                                                rsp_match_o,
  output logic [IdxWidth-1:0]                                 rsp_idx_o,
  output write_guard_pkg::phase_e [NumSlots-1:0]              phase_o,
  output logic [NumSlots-1:0][write_guard_pkg::AddrWidth-1:0] slot_addr_o
);
  import write_guard_pkg::*;

  logic [NumSlots-1:0][IdWidth-1:0]   id_q;
  logic [NumSlots-1:0][AddrWidth-1:0] addr_q;
  phase_e [NumSlots-1:0]              phase_q;
  logic [NumSlots-1:0][IdxWidth-1:0]  rank_q;
  logic [NumSlots-1:0][IdxWidth-1:0]  rank_d;
  logic [NumSlots-1:0]                keep;
  logic [IdxWidth-1:0]                alloc_rank;

  // Slots that stay live past this edge
  for (genvar i = 0; i < NumSlots; i++) begin : gen_keep
    assign keep[i] = (phase_q[i] != PH_FREE) && !release_i[i];
  end

  // A rank counts the older live writes with the same ID, so releases
  // anywhere in the chain close the gap by themselves
  always_comb begin
    alloc_rank = '0;
    for (int j = 0; j < NumSlots; j++) begin
      if (keep[j] && (id_q[j] == aw_id_i)) begin
        alloc_rank = alloc_rank + 1'b1;
      end
    end
    for (int i = 0; i < NumSlots; i++) begin
      rank_d[i] = '0;
      for (int j = 0; j < NumSlots; j++) begin
        if ((j != i) && keep[j] && (id_q[j] == id_q[i]) && (rank_q[j] < rank_q[i])) begin
          rank_d[i] = rank_d[i] + 1'b1;
        end
      end
    end
    if (alloc_i) begin
      rank_d[alloc_idx_i] = alloc_rank;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= {NumSlots{PH_FREE}};
      rank_q  <= '0;
    end else begin
      rank_q <= rank_d;
      for (int i = 0; i < NumSlots; i++) begin
        if (release_i[i]) begin
          phase_q[i] <= PH_FREE;
        end else if (alloc_i && (alloc_idx_i == IdxWidth'(i))) begin
          phase_q[i] <= PH_DATA;
        end else if (to_resp_i && (resp_idx_i == IdxWidth'(i))) begin
          phase_q[i] <= PH_RESP;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      id_q[alloc_idx_i]   <= aw_id_i;
      addr_q[alloc_idx_i] <= aw_addr_i;
    end
  end

  // Lowest free slot, and the oldest response-ready slot for b_id
  always_comb begin
    free_found_o = 1'b0;
    free_idx_o   = '0;
    rsp_match_o  = 1'b0;
    rsp_idx_o    = '0;
    for (int i = NumSlots - 1; i >= 0; i--) begin
      if (phase_q[i] == PH_FREE) begin
        free_found_o = 1'b1;
        free_idx_o   = IdxWidth'(i);
      end
      if ((phase_q[i] == PH_RESP) && (id_q[i] == b_id_i) && (rank_q[i] == '0)) begin
        rsp_match_o = 1'b1;
        rsp_idx_o   = IdxWidth'(i);
      end
    end
  end

  assign phase_o     = phase_q;
  assign slot_addr_o = addr_q;

endmodule

/* wg_timer_bank.sv */
`timescale 1ns/1ps

module wg_timer_bank #(
  parameter  int unsigned NumSlots = 4,
  localparam int unsigned IdxWidth = (NumSlots > 1) ? $clog2(NumSlots) : 1
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   alloc_i,
  input  logic [IdxWidth-1:0]                    alloc_idx_i,
  input  logic [write_guard_pkg::LenWidth-1:0]   aw_len_i,
  input  logic                                   to_resp_i,
  input  logic [IdxWidth-1:0]                    resp_idx_i,
  input  write_guard_pkg::phase_e [NumSlots-1:0] phase_i,
  input  logic                                   aw_valid_i,
  input  logic                                   aw_ready_i,
  input  logic [write_guard_pkg::CntWidth-1:0]   budget_aw_i,
  input  logic [write_guard_pkg::CntWidth-1:0]   budget_w_i,
  input  logic [write_guard_pkg::CntWidth-1:0]   budget_b_i,
  output logic [NumSlots-1:0]                    expire_o,
  output logic                                   aw_stall_expire_o
);
  import write_guard_pkg::*;

  logic [NumSlots-1:0][CntWidth-1:0] cnt_q;
  logic [NumSlots-1:0][CntWidth-1:0] limit_q;
  logic [CntWidth-1:0]               data_limit;
  logic [CntWidth-1:0]               stall_cnt_q;
  logic                              aw_stall;

  // Per-beat budget times the number of beats
  assign data_limit = budget_w_i * ({{(CntWidth - LenWidth){1'b0}}, aw_len_i} + 1'b1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < NumSlots; i++) begin
        if ((alloc_i && (alloc_idx_i == IdxWidth'(i))) ||
            (to_resp_i && (resp_idx_i == IdxWidth'(i)))) begin
          cnt_q[i] <= '0;
        end else if (phase_i[i] != PH_FREE) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      limit_q[alloc_idx_i] <= data_limit;
    end
  end

  for (genvar i = 0; i < NumSlots; i++) begin : gen_expire
    assign expire_o[i] = ((phase_i[i] == PH_DATA) && (cnt_q[i] == limit_q[i])) ||
                         ((phase_i[i] == PH_RESP) && (cnt_q[i] == budget_b_i));
  end

  assign aw_stall = aw_valid_i && !aw_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stall_cnt_q <= '0;
    end else if (aw_stall) begin
      stall_cnt_q <= stall_cnt_q + 1'b1;
    end else begin
      stall_cnt_q <= '0;
    end
  end

  assign aw_stall_expire_o = aw_stall && (stall_cnt_q == budget_aw_i);

endmodule

/* wg_w_order_fifo.sv */
`timescale 1ns/1ps

module wg_w_order_fifo #(
  parameter  int unsigned NumSlots = 4,
  localparam int unsigned IdxWidth = (NumSlots > 1) ? $clog2(NumSlots) : 1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                push_i,
  input  logic [IdxWidth-1:0] push_idx_i,
  input  logic                pop_i,
  output logic [IdxWidth-1:0] head_o,
  output logic                empty_o
);

  localparam int unsigned CountWidth = $clog2(NumSlots + 1);

  logic [NumSlots-1:0][IdxWidth-1:0] mem_q;
  logic [IdxWidth-1:0]               rd_ptr_q;
  logic [IdxWidth-1:0]               wr_ptr_q;
  logic [CountWidth-1:0]             count_q;
  logic                              do_push;
  logic                              do_pop;

  assign empty_o = (count_q == '0);
  assign do_pop  = pop_i && !empty_o;
  // A slot reused after a data timeout must not overrun the buffer
  assign do_push = push_i && ((count_q != CountWidth'(NumSlots)) || do_pop);
  assign head_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == IdxWidth'(NumSlots - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == IdxWidth'(NumSlots - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_idx_i;
    end
  end

endmodule

/* write_guard.sv */
`timescale 1ns/1ps

module write_guard #(
  parameter int unsigned NumSlots = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Write address channel
  input  logic                                  aw_valid_i,
  input  logic                                  aw_ready_i,
  input  logic [write_guard_pkg::IdWidth-1:0]   aw_id_i,
  input  logic [write_guard_pkg::AddrWidth-1:0] aw_addr_i,
  input  logic [write_guard_pkg::LenWidth-1:0]  aw_len_i,
  // Write data channel
  input  logic                                  w_valid_i,
  input  logic                                  w_ready_i,
  input  logic                                  w_last_i,
  // Write response channel
  input  logic                                  b_valid_i,
  input  logic                                  b_ready_i,
  input  logic [write_guard_pkg::IdWidth-1:0]   b_id_i,
  // Time budgets in cycles
  input  logic [write_guard_pkg::CntWidth-1:0]  budget_aw_i,
  input  logic [write_guard_pkg::CntWidth-1:0]  budget_w_i,
  input  logic [write_guard_pkg::CntWidth-1:0]  budget_b_i,
  input  logic                                  clear_i,
  output logic                                  irq_o,
  output logic                                  reset_req_o,
  output write_guard_pkg::fault_e               fault_cause_o,
  output logic [write_guard_pkg::AddrWidth-1:0] fault_addr_o
);
  import write_guard_pkg::*;

  localparam int unsigned IdxWidth = (NumSlots > 1) ? $clog2(NumSlots) : 1;

  logic                                alloc;
  logic [IdxWidth-1:0]                 alloc_idx;
  logic                                to_resp;
  logic [IdxWidth-1:0]                 resp_idx;
  logic [NumSlots-1:0]                 release_vec;
  logic                                free_found;
  logic [IdxWidth-1:0]                 free_idx;
  logic                                rsp_match;
  logic [IdxWidth-1:0]                 rsp_idx;
  phase_e [NumSlots-1:0]               phase;
  logic [NumSlots-1:0][AddrWidth-1:0]  slot_addr;
  logic [IdxWidth-1:0]                 w_head;
  logic                                w_empty;
  logic [NumSlots-1:0]                 expire;
  logic                                aw_stall_expire;
  logic                                fault_req;
  fault_e                              fault_cause_req;
  logic [AddrWidth-1:0]                fault_addr_req;

  wg_ctrl #(
    .NumSlots (NumSlots)
  ) i_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .aw_valid_i        (aw_valid_i),
    .aw_ready_i        (aw_ready_i),
    .w_valid_i         (w_valid_i),
    .w_ready_i         (w_ready_i),
    .w_last_i          (w_last_i),
    .b_valid_i         (b_valid_i),
    .b_ready_i         (b_ready_i),
    .free_found_i      (free_found),
    .free_idx_i        (free_idx),
    .rsp_match_i       (rsp_match),
    .rsp_idx_i         (rsp_idx),
    .w_head_i          (w_head),
    .w_empty_i         (w_empty),
    .expire_i          (expire),
    .aw_stall_expire_i (aw_stall_expire),
    .phase_i           (phase),
    .slot_addr_i       (slot_addr),
    .aw_addr_i         (aw_addr_i),
    .alloc_o           (alloc),
    .alloc_idx_o       (alloc_idx),
    .to_resp_o         (to_resp),
    .resp_idx_o        (resp_idx),
    .release_o         (release_vec),
    .fault_req_o       (fault_req),
    .fault_cause_o     (fault_cause_req),
    .fault_addr_o      (fault_addr_req)
  );

  wg_slot_table #(
    .NumSlots (NumSlots)
  ) i_slot_table (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .alloc_i      (alloc),
    .alloc_idx_i  (alloc_idx),
    .aw_id_i      (aw_id_i),
    .aw_addr_i    (aw_addr_i),
    .to_resp_i    (to_resp),
    .resp_idx_i   (resp_idx),
    .release_i    (release_vec),
    .b_id_i       (b_id_i),
    .free_found_o (free_found),
    .free_idx_o   (free_idx),
    .rsp_match_o  (rsp_match),
    .rsp_idx_o    (rsp_idx),
    .phase_o      (phase),
    .slot_addr_o  (slot_addr)
  );

  // W bursts follow address order, each burst leaves on its last beat
  wg_w_order_fifo #(
    .NumSlots (NumSlots)
  ) i_w_order_fifo (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .push_i     (alloc),
    .push_idx_i (free_idx),
    .pop_i      (w_valid_i && w_ready_i && w_last_i),
    .head_o     (w_head),
    .empty_o    (w_empty)
  );

  wg_timer_bank #(
    .NumSlots (NumSlots)
  ) i_timer_bank (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .alloc_i           (alloc),
    .alloc_idx_i       (alloc_idx),
    .aw_len_i          (aw_len_i),
    .to_resp_i         (to_resp),
    .resp_idx_i        (resp_idx),
    .phase_i           (phase),
    .aw_valid_i        (aw_valid_i),
    .aw_ready_i        (aw_ready_i),
    .budget_aw_i       (budget_aw_i),
    .budget_w_i        (budget_w_i),
    .budget_b_i        (budget_b_i),
    .expire_o          (expire),
    .aw_stall_expire_o (aw_stall_expire)
  );

  wg_fault_log i_fault_log (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fault_req_i   (fault_req),
    .fault_cause_i (fault_cause_req),
    .fault_addr_i  (fault_addr_req),
    .clear_i       (clear_i),
    .irq_o         (irq_o),
    .reset_req_o   (reset_req_o),
    .fault_cause_o (fault_cause_o),
    .fault_addr_o  (fault_addr_o)
  );

endmodule

/* write_guard_assert.sv */
`timescale 1ns/1ps

module write_guard_assert (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    clear_i,
  input logic                    irq_o,
  input logic                    reset_req_o,
  input write_guard_pkg::fault_e fault_cause_o
);
  import write_guard_pkg::*;

  // Number of failed assertions so far
  int unsigned fail_cnt = 0;

  // Interrupt and reset request are one level
  a_irq_eq_reset : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    irq_o == reset_req_o
  ) else begin
    fail_cnt++;
    $error("irq_o and reset_req_o differ");
  end

  // A cause is shown exactly while the interrupt is up
  a_cause_with_irq : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (fault_cause_o == FAULT_NONE) == !irq_o
  ) else begin
    fail_cnt++;
    $error("fault cause does not match irq_o");
  end

  a_irq_held : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (irq_o && !clear_i) |=> irq_o
  ) else begin
    fail_cnt++;
    $error("irq_o dropped without clear");
  end

endmodule

/* write_guard_pkg.sv */
package write_guard_pkg;

  // AXI ID width
  localparam int unsigned IdWidth = 4;

  // Write address width
  localparam int unsigned AddrWidth = 32;

  // Burst length field, beats = len + 1
  localparam int unsigned LenWidth = 8;

  // Timers and budgets
  localparam int unsigned CntWidth = 16;

  // Life cycle of one outstanding write
  typedef enum logic [1:0] {
    // Slot unused
    PH_FREE = 2'd0,
    // Address accepted, waiting for the last W beat
    PH_DATA = 2'd1,
    // Last beat seen, waiting for the B response
    PH_RESP = 2'd2
  } phase_e;

  // Cause of the latched fault
  typedef enum logic [2:0] {
    FAULT_NONE       = 3'd0,
    FAULT_AW_STALL   = 3'd1,
    FAULT_W_TIMEOUT  = 3'd2,
    FAULT_B_TIMEOUT  = 3'd3,
    FAULT_UNWANTED_B = 3'd4,
    FAULT_TABLE_FULL = 3'd5
  } fault_e;

endpackage
